//--- bcast_icnt_pkg.sv
`default_nettype none

package bcast_icnt_pkg;

  localparam int ch_num    = 8;                  // Memory-side controller channels
  localparam int ch_addr_w = $clog2(ch_num);     // Channel index width
  localparam int data_w    = 32;                 // Payload word width

  typedef logic [ch_addr_w-1:0] ch_addr_t;       // Channel index
  typedef logic [ch_num-1:0]    ch_mask_t;       // One bit per channel
  typedef logic [data_w-1:0]    data_t;          // Payload word
  typedef logic [1:0]           prio_t;          // Request priority
  typedef logic [3:0]           req_type_t;      // Command encoding
  typedef logic [3:0]           bk_addr_t;       // Bank address
  typedef logic [13:0]          row_addr_t;      // Row address
  typedef logic [5:0]           col_addr_t;      // Column address

  typedef struct packed {
    logic      marker;                           // Packet marker bit
    logic      bcast;                            // Broadcast request or response
    prio_t     prio;
    req_type_t req_type;
    bk_addr_t  bk_addr;
    row_addr_t row_addr;
    col_addr_t col_addr;
    data_t     data;                             // Payload
  } pkt_t;

  // Header kept per in-flight broadcast, data is rebuilt as zero
  typedef struct packed {
    logic      marker;
    logic      bcast;
    prio_t     prio;
    req_type_t req_type;
    bk_addr_t  bk_addr;
    row_addr_t row_addr;
    col_addr_t col_addr;
  } pkt_hdr_t;

  function automatic pkt_hdr_t pkt_hdr(pkt_t p);
    pkt_hdr_t h;
    h.marker   = p.marker;
    h.bcast    = p.bcast;
    h.prio     = p.prio;
    h.req_type = p.req_type;
    h.bk_addr  = p.bk_addr;
    h.row_addr = p.row_addr;
    h.col_addr = p.col_addr;
    return h;
  endfunction

  function automatic pkt_t hdr_pkt(pkt_hdr_t h);
    pkt_t p;
    p          = '0;                             // Combined response carries no data
    p.marker   = h.marker;
    p.bcast    = h.bcast;
    p.prio     = h.prio;
    p.req_type = h.req_type;
    p.bk_addr  = h.bk_addr;
    p.row_addr = h.row_addr;
    p.col_addr = h.col_addr;
    return p;
  endfunction

endpackage

`default_nettype wire

//--- sync_fifo.sv
`default_nettype none

module sync_fifo #(
  parameter int width  = 64,
  parameter int depth  = 16,
  parameter int thresh = 12
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr,
  input  logic [width-1:0] din,
  input  logic             rd,
  output logic [width-1:0] dout,
  output logic             empty,
  output logic             full,
  output logic             above_thresh
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  typedef logic [ptr_w-1:0] ptr_t;               // Buffer slot index
  typedef logic [cnt_w-1:0] cnt_t;               // Fill level, 0 to depth

  logic [width-1:0] mem [depth];                 // Storage, no reset
  ptr_t             wr_ptr;
  ptr_t             rd_ptr;
  cnt_t             count;
  logic             do_wr;
  logic             do_rd;

  // Wrap at depth so non power-of-2 depths work
  function automatic ptr_t ptr_inc(ptr_t p);
    return (p == ptr_t'(depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign do_wr = wr && !full;                    // Overflowing write is dropped
  assign do_rd = rd && !empty;                   // Underflowing read is ignored

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
      if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
      count <= count + cnt_t'(do_wr) - cnt_t'(do_rd);
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= din;
  end

  assign dout         = mem[rd_ptr];             // First word falls through
  assign empty        = (count == '0);
  assign full         = (count == cnt_t'(depth));
  assign above_thresh = (count >= cnt_t'(thresh));

  a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr |-> !full)
    else $error("sync_fifo: write while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd |-> !empty)
    else $error("sync_fifo: read while empty");

endmodule

`default_nettype wire

//--- req_dispatch.sv
`default_nettype none

module req_dispatch #(
  parameter int entry_depth = 16
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     dma_pkt_valid,
  input  bcast_icnt_pkg::pkt_t     dma_pkt,
  input  bcast_icnt_pkg::ch_mask_t dma_pkt_ch_mask,
  input  bcast_icnt_pkg::ch_mask_t aimc_rdy,
  input  logic                     bcast_pipe_full,
  input  logic                     resp_backlog,
  output logic                     icnt_rdy,
  output bcast_icnt_pkg::ch_mask_t icnt_aimc_pkt_valid,
  output bcast_icnt_pkg::pkt_t     icnt_aimc_pkt,
  output logic                     bcast_issue,
  output bcast_icnt_pkg::ch_mask_t bcast_issue_mask,
  output bcast_icnt_pkg::pkt_hdr_t bcast_issue_hdr
);

  import bcast_icnt_pkg::*;

  // Packet and its mask share one queue word
  typedef struct packed {
    ch_mask_t mask;                              // Index in low bits for unicast
    pkt_t     pkt;
  } entry_t;

  entry_t   entry_din;
  entry_t   entry_dout;                          // Head of the entry queue
  logic     entry_wr;
  logic     entry_rd;
  logic     entry_empty;
  logic     entry_full;
  ch_addr_t ucast_ch;                            // Target of a unicast head
  logic     bcast_go;                            // Broadcast head can leave

  sync_fifo #(
    .width  ($bits(entry_t)),
    .depth  (entry_depth),
    .thresh (entry_depth)
  ) entry_que (
    .clk          (clk),
    .rst          (rst),
    .wr           (entry_wr),
    .din          (entry_din),
    .rd           (entry_rd),
    .dout         (entry_dout),
    .empty        (entry_empty),
    .full         (entry_full),
    .above_thresh ()
  );

  assign icnt_rdy  = !entry_full && !resp_backlog;  // Hold off the DMA while responses pile up
  assign entry_wr  = dma_pkt_valid && icnt_rdy;
  assign entry_din = '{mask: dma_pkt_ch_mask, pkt: dma_pkt};

  assign icnt_aimc_pkt = entry_dout.pkt;         // One shared bus to all controllers
  assign ucast_ch      = entry_dout.mask[ch_addr_w-1:0];

  // All masked channels must be ready at once, no partial issue
  assign bcast_go = !entry_empty && entry_dout.pkt.bcast && !bcast_pipe_full &&
                    ((aimc_rdy & entry_dout.mask) == entry_dout.mask);

  always_comb begin
    icnt_aimc_pkt_valid = '0;
    entry_rd            = 1'b0;
    if (entry_dout.pkt.bcast) begin
      icnt_aimc_pkt_valid = bcast_go ? entry_dout.mask : '0;
      entry_rd            = bcast_go;
    end else begin
      icnt_aimc_pkt_valid[ucast_ch] = !entry_empty;  // Only the addressed channel
      entry_rd                      = !entry_empty && aimc_rdy[ucast_ch];
    end
  end

  assign bcast_issue      = bcast_go;            // Opens a collector entry
  assign bcast_issue_mask = entry_dout.mask;
  assign bcast_issue_hdr  = pkt_hdr(entry_dout.pkt);

  a_bcast_mask: assert property (@(posedge clk) disable iff (rst)
    (!entry_empty && entry_dout.pkt.bcast) |-> (entry_dout.mask != '0))
    else $error("req_dispatch: broadcast with empty channel mask");

endmodule

`default_nettype wire

//--- bcast_resp_collector.sv
`default_nettype none

module bcast_resp_collector #(
  parameter int bcast_pipe_len = 4
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     bcast_issue,
  input  bcast_icnt_pkg::ch_mask_t bcast_issue_mask,
  input  bcast_icnt_pkg::pkt_hdr_t bcast_issue_hdr,
  input  bcast_icnt_pkg::ch_mask_t aimc_pkt_valid,
  input  bcast_icnt_pkg::pkt_t     aimc_pkt [bcast_icnt_pkg::ch_num],
  input  logic                     bcast_pull,
  output logic                     bcast_pipe_full,
  output logic                     bcast_done,
  output bcast_icnt_pkg::pkt_hdr_t bcast_done_hdr
);

  import bcast_icnt_pkg::*;

  localparam int slot_w = (bcast_pipe_len > 1) ? $clog2(bcast_pipe_len) : 1;
  localparam int cnt_w  = $clog2(bcast_pipe_len + 1);

  typedef logic [slot_w-1:0] slot_t;             // Ring slot index
  typedef logic [cnt_w-1:0]  cnt_t;              // In-flight broadcasts

  pkt_hdr_t hdr_mem [bcast_pipe_len];            // Request headers
  ch_mask_t pend    [bcast_pipe_len];            // Channels still to answer
  ch_mask_t clr     [bcast_pipe_len];            // Bits answered this cycle
  slot_t    wr_ptr;
  slot_t    rd_ptr;                              // Oldest broadcast
  cnt_t     count;
  ch_mask_t resp_hit;                            // Broadcast responses this cycle
  ch_mask_t miss;                                // Responses with nothing to clear

  function automatic slot_t slot_inc(slot_t s);
    return (s == slot_t'(bcast_pipe_len - 1)) ? '0 : s + 1'b1;
  endfunction

  // Free slots hold a zero mask, so the search needs no ring bounds
  always_comb begin
    slot_t s;
    logic  found;
    clr  = '{default: '0};
    miss = '0;
    for (int c = 0; c < ch_num; c++) begin
      resp_hit[c] = aimc_pkt_valid[c] && aimc_pkt[c].bcast;
      s           = rd_ptr;
      found       = 1'b0;
      for (int k = 0; k < bcast_pipe_len; k++) begin
        if (!found && pend[s][c]) begin          // Oldest entry still waiting on c
          clr[s][c] = resp_hit[c];
          found     = 1'b1;
        end
        s = slot_inc(s);
      end
      miss[c] = resp_hit[c] && !found;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pend   <= '{default: '0};
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      for (int k = 0; k < bcast_pipe_len; k++) begin
        pend[k] <= pend[k] & ~clr[k];
      end
      if (bcast_issue) begin
        pend[wr_ptr] <= bcast_issue_mask;        // Slot is free, nothing to clear there
        wr_ptr       <= slot_inc(wr_ptr);
      end
      if (bcast_pull) rd_ptr <= slot_inc(rd_ptr);
      count <= count + cnt_t'(bcast_issue) - cnt_t'(bcast_pull);
    end
  end

  always_ff @(posedge clk) begin
    if (bcast_issue) hdr_mem[wr_ptr] <= bcast_issue_hdr;
  end

  assign bcast_pipe_full = (count == cnt_t'(bcast_pipe_len));
  assign bcast_done      = (count != '0) && (pend[rd_ptr] == '0);  // All channels answered
  assign bcast_done_hdr  = hdr_mem[rd_ptr];

  a_no_orphan: assert property (@(posedge clk) disable iff (rst) miss == '0)
    else $error("bcast_resp_collector: broadcast response with no outstanding request");

endmodule

`default_nettype wire

//--- resp_arbiter.sv
`default_nettype none

module resp_arbiter #(
  parameter int resp_depth  = 32,
  parameter int resp_thresh = 24
) (
  input  logic                     clk,
  input  logic                     rst,
  input  bcast_icnt_pkg::ch_mask_t aimc_pkt_valid,
  input  bcast_icnt_pkg::pkt_t     aimc_pkt [bcast_icnt_pkg::ch_num],
  input  logic                     bcast_done,
  input  bcast_icnt_pkg::pkt_hdr_t bcast_done_hdr,
  input  logic                     dma_rdy,
  output logic                     bcast_pull,
  output logic                     resp_backlog,
  output logic                     icnt_dma_pkt_valid,
  output bcast_icnt_pkg::pkt_t     icnt_dma_pkt,
  output bcast_icnt_pkg::ch_addr_t icnt_dma_pkt_ch_addr
);

  import bcast_icnt_pkg::*;

  ch_mask_t q_wr;                                // Unicast response into queue
  ch_mask_t q_rd;
  ch_mask_t q_empty;
  ch_mask_t q_above;                             // Queue past its threshold
  pkt_t     q_dout [ch_num];                     // Queue heads
  ch_addr_t rr_base;                             // First channel to look at
  ch_addr_t rr_sel;                              // Picked channel
  logic     rr_hit;                              // Some queue has a response
  logic     out_load;                            // Output register can take a word
  logic     ucast_pull;

  for (genvar i = 0; i < ch_num; i++) begin : g_resp_que
    assign q_wr[i] = aimc_pkt_valid[i] && !aimc_pkt[i].bcast;  // Broadcasts go to the collector
    assign q_rd[i] = ucast_pull && (rr_sel == ch_addr_t'(i));

    sync_fifo #(
      .width  ($bits(pkt_t)),
      .depth  (resp_depth),
      .thresh (resp_thresh)
    ) resp_que (
      .clk          (clk),
      .rst          (rst),
      .wr           (q_wr[i]),
      .din          (aimc_pkt[i]),
      .rd           (q_rd[i]),
      .dout         (q_dout[i]),
      .empty        (q_empty[i]),
      .full         (),
      .above_thresh (q_above[i])
    );
  end

  // Scan downward so the nearest queue at or after the base wins
  always_comb begin
    ch_addr_t idx;
    rr_sel = rr_base;
    rr_hit = 1'b0;
    for (int k = ch_num - 1; k >= 0; k--) begin
      idx = ch_addr_t'((int'(rr_base) + k) % ch_num);
      if (!q_empty[idx]) begin
        rr_sel = idx;
        rr_hit = 1'b1;
      end
    end
  end

  assign out_load   = !icnt_dma_pkt_valid || dma_rdy;     // Empty or being drained
  assign bcast_pull = out_load && bcast_done;             // Broadcast has priority
  assign ucast_pull = out_load && !bcast_done && rr_hit;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      icnt_dma_pkt_valid <= 1'b0;
      rr_base            <= '0;
      resp_backlog       <= 1'b0;
    end else begin
      if (out_load) icnt_dma_pkt_valid <= bcast_pull || ucast_pull;
      if (ucast_pull) rr_base <= ch_addr_t'((int'(rr_sel) + 1) % ch_num);  // One past winner
      resp_backlog <= |q_above;
    end
  end

  always_ff @(posedge clk) begin
    if (bcast_pull) begin
      icnt_dma_pkt         <= hdr_pkt(bcast_done_hdr);  // Header with zero data
      icnt_dma_pkt_ch_addr <= '0;
    end else if (ucast_pull) begin
      icnt_dma_pkt         <= q_dout[rr_sel];
      icnt_dma_pkt_ch_addr <= rr_sel;
    end
  end

  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    (icnt_dma_pkt_valid && !dma_rdy) |=> (icnt_dma_pkt_valid && $stable(icnt_dma_pkt) &&
                                          $stable(icnt_dma_pkt_ch_addr)))
    else $error("resp_arbiter: output changed while stalled");

endmodule

`default_nettype wire

//--- bcast_icnt.sv
`default_nettype none

module bcast_icnt #(
  parameter int entry_depth    = 16,
  parameter int resp_depth     = 32,
  parameter int resp_thresh    = 24,
  parameter int bcast_pipe_len = 4
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     dma_pkt_valid,        // DMA request side
  input  bcast_icnt_pkg::pkt_t     dma_pkt,
  input  bcast_icnt_pkg::ch_mask_t dma_pkt_ch_mask,
  output logic                     icnt_rdy,
  output bcast_icnt_pkg::ch_mask_t icnt_aimc_pkt_valid,  // Controller request side
  output bcast_icnt_pkg::pkt_t     icnt_aimc_pkt,
  input  bcast_icnt_pkg::ch_mask_t aimc_rdy,
  input  bcast_icnt_pkg::ch_mask_t aimc_pkt_valid,       // Controller responses
  input  bcast_icnt_pkg::pkt_t     aimc_pkt [bcast_icnt_pkg::ch_num],
  output logic                     icnt_dma_pkt_valid,   // DMA response side
  output bcast_icnt_pkg::pkt_t     icnt_dma_pkt,
  output bcast_icnt_pkg::ch_addr_t icnt_dma_pkt_ch_addr,
  input  logic                     dma_rdy
);

  import bcast_icnt_pkg::*;

  logic     bcast_issue;                         // Broadcast left the entry queue
  ch_mask_t bcast_issue_mask;
  pkt_hdr_t bcast_issue_hdr;
  logic     bcast_pipe_full;
  logic     bcast_done;                          // Oldest broadcast fully answered
  pkt_hdr_t bcast_done_hdr;
  logic     bcast_pull;
  logic     resp_backlog;                        // Response queues filling up

  req_dispatch #(
    .entry_depth (entry_depth)
  ) u_dispatch (
    .clk                 (clk),
    .rst                 (rst),
    .dma_pkt_valid       (dma_pkt_valid),
    .dma_pkt             (dma_pkt),
    .dma_pkt_ch_mask     (dma_pkt_ch_mask),
    .aimc_rdy            (aimc_rdy),
    .bcast_pipe_full     (bcast_pipe_full),
    .resp_backlog        (resp_backlog),
    .icnt_rdy            (icnt_rdy),
    .icnt_aimc_pkt_valid (icnt_aimc_pkt_valid),
    .icnt_aimc_pkt       (icnt_aimc_pkt),
    .bcast_issue         (bcast_issue),
    .bcast_issue_mask    (bcast_issue_mask),
    .bcast_issue_hdr     (bcast_issue_hdr)
  );

  bcast_resp_collector #(
    .bcast_pipe_len (bcast_pipe_len)
  ) u_collector (
    .clk              (clk),
    .rst              (rst),
    .bcast_issue      (bcast_issue),
    .bcast_issue_mask (bcast_issue_mask),
    .bcast_issue_hdr  (bcast_issue_hdr),
    .aimc_pkt_valid   (aimc_pkt_valid),
    .aimc_pkt         (aimc_pkt),
    .bcast_pull       (bcast_pull),
    .bcast_pipe_full  (bcast_pipe_full),
    .bcast_done       (bcast_done),
    .bcast_done_hdr   (bcast_done_hdr)
  );

  resp_arbiter #(
    .resp_depth  (resp_depth),
    .resp_thresh (resp_thresh)
  ) u_arbiter (
    .clk                  (clk),
    .rst                  (rst),
    .aimc_pkt_valid       (aimc_pkt_valid),
    .aimc_pkt             (aimc_pkt),
    .bcast_done           (bcast_done),
    .bcast_done_hdr       (bcast_done_hdr),
    .dma_rdy              (dma_rdy),
    .bcast_pull           (bcast_pull),
    .resp_backlog         (resp_backlog),
    .icnt_dma_pkt_valid   (icnt_dma_pkt_valid),
    .icnt_dma_pkt         (icnt_dma_pkt),
    .icnt_dma_pkt_ch_addr (icnt_dma_pkt_ch_addr)
  );

endmodule

`default_nettype wire

//--- tb_bcast_icnt.sv
`default_nettype none

module tb_bcast_icnt;

  import bcast_icnt_pkg::*;

  localparam int n_req   = 300;                  // Requests sent by the DMA model
  localparam int t_limit = 200 * n_req + 500;    // Cycle budget for the whole run

  typedef struct packed {
    ch_mask_t mask;
    pkt_t     pkt;
  } req_t;                                       // Request as the DMA sent it

  typedef struct packed {
    pkt_t        pkt;
    logic [31:0] due;                            // Cycle the answer may go out
  } model_t;

  typedef struct packed {
    ch_mask_t outs;                              // Channels yet to answer
    pkt_t     pkt;
  } bc_t;

  logic     clk = 1'b0;
  logic     rst;
  logic     dma_pkt_valid;
  pkt_t     dma_pkt;
  ch_mask_t dma_pkt_ch_mask;
  logic     icnt_rdy;
  ch_mask_t icnt_aimc_pkt_valid;
  pkt_t     icnt_aimc_pkt;
  ch_mask_t aimc_rdy;
  ch_mask_t aimc_pkt_valid;
  pkt_t     aimc_pkt [ch_num];
  logic     icnt_dma_pkt_valid;
  pkt_t     icnt_dma_pkt;
  ch_addr_t icnt_dma_pkt_ch_addr;
  logic     dma_rdy;

  logic [15:0] lfsr = 16'd50781;
  int          cycle = 0;
  int          errors = 0;
  int          n_checks = 0;
  int          n_uc = 0;                         // Unicast responses taken
  int          n_bc = 0;                         // Broadcast responses taken
  logic        stalled = 1'b0;                   // Output held by dma_rdy last edge
  pkt_t        held_pkt;
  ch_addr_t    held_ch;
  req_t        sent_q [$];                       // Accepted, not yet dispatched
  pkt_t        exp_uc [ch_num][$];
  bc_t         exp_bc [$];                       // In issue order
  model_t      model_q [ch_num][$];

  bcast_icnt #(
    .entry_depth    (16),
    .resp_depth     (32),
    .resp_thresh    (24),
    .bcast_pipe_len (4)
  ) DUT (
    .clk                  (clk),
    .rst                  (rst),
    .dma_pkt_valid        (dma_pkt_valid),
    .dma_pkt              (dma_pkt),
    .dma_pkt_ch_mask      (dma_pkt_ch_mask),
    .icnt_rdy             (icnt_rdy),
    .icnt_aimc_pkt_valid  (icnt_aimc_pkt_valid),
    .icnt_aimc_pkt        (icnt_aimc_pkt),
    .aimc_rdy             (aimc_rdy),
    .aimc_pkt_valid       (aimc_pkt_valid),
    .aimc_pkt             (aimc_pkt),
    .icnt_dma_pkt_valid   (icnt_dma_pkt_valid),
    .icnt_dma_pkt         (icnt_dma_pkt),
    .icnt_dma_pkt_ch_addr (icnt_dma_pkt_ch_addr),
    .dma_rdy              (dma_rdy)
  );

  always #20 clk = ~clk;

  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Galois form, taps 16 14 13 11
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};                 // One step per bit
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  // Controller answer: data scrambled by channel and row
  function automatic data_t resp_data(pkt_t req, ch_addr_t ch);
    return req.data ^ {8'(ch) * 8'h11, 10'b0, req.row_addr};
  endfunction

  task automatic report_failure(string msg);
    errors++;
    $display("%s at time %0t", msg, $time);
  endtask

  task automatic check_pkt(string name, pkt_t got, pkt_t exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got %h expected %h at time %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_ch(string name, ch_addr_t got, ch_addr_t exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got %h expected %h at time %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_mask(string name, ch_mask_t got, ch_mask_t exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got %h expected %h at time %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_reset();
    check_mask("icnt_aimc_pkt_valid", icnt_aimc_pkt_valid, '0);
    if (icnt_dma_pkt_valid !== 1'b0) report_failure("icnt_dma_pkt_valid not low around reset");
  endtask

  task automatic finish_run();
    $display("Checks %0d, unicast responses %0d, broadcast responses %0d, errors %0d",
             n_checks, n_uc, n_bc, errors);
    if (errors == 0) $display("*** TEST PASSED ***");
    else $display("*** TEST FAILED ***");
    $finish;
  endtask

  function automatic logic drained();
    logic d;
    d = (sent_q.size() == 0) && (exp_bc.size() == 0) && !icnt_dma_pkt_valid;
    for (int i = 0; i < ch_num; i++) d = d && (exp_uc[i].size() == 0) && (model_q[i].size() == 0);
    return d;
  endfunction

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= t_limit) begin
      report_failure($sformatf("Timeout after %0d cycles, traffic did not drain", t_limit));
      finish_run();
    end
  end

  // Controller ready bits, dma_rdy and model answers
  always @(posedge clk) begin
    #2;
    if (!rst) begin
      for (int i = 0; i < ch_num; i++) aimc_rdy[i] = (rand_bits(3) != 0);  // Ready 7 of 8
      dma_rdy = (rand_bits(2) != 0);
      for (int i = 0; i < ch_num; i++) begin
        aimc_pkt_valid[i] = 1'b0;
        if (model_q[i].size() != 0 && model_q[i][0].due <= cycle) begin  // In order per channel
          aimc_pkt[i]       = model_q[i][0].pkt;
          aimc_pkt_valid[i] = 1'b1;
          void'(model_q[i].pop_front());
        end
      end
    end
  end

  // Scoreboard and compare process
  always @(posedge clk) begin
    req_t     r;
    bc_t      b;
    model_t   mdl;
    ch_addr_t ch;
    ch_mask_t acc;
    logic     placed;
    if (!rst) begin
      if (dma_pkt_valid && icnt_rdy) begin
        r.mask = dma_pkt_ch_mask;                // Request as it entered the DUT
        r.pkt  = dma_pkt;
        sent_q.push_back(r);
      end
      acc = icnt_aimc_pkt_valid & aimc_rdy;      // Models take what they see
      for (int i = 0; i < ch_num; i++) begin
        if (acc[i]) begin
          mdl.pkt      = icnt_aimc_pkt;
          mdl.pkt.data = resp_data(icnt_aimc_pkt, ch_addr_t'(i));
          mdl.due      = cycle + 1 + rand_bits(3);  // 1 to 8 cycles
          model_q[i].push_back(mdl);
        end
      end
      if (icnt_aimc_pkt_valid != '0) begin
        if (sent_q.size() == 0) begin
          report_failure("Controller valid raised with no request waiting");
        end else begin
          r = sent_q[0];
          if (r.pkt.bcast) begin
            check_mask("icnt_aimc_pkt_valid", icnt_aimc_pkt_valid, r.mask);
            if ((aimc_rdy & r.mask) != r.mask)
              report_failure("Broadcast issued while a masked channel was not ready");
            check_pkt("icnt_aimc_pkt", icnt_aimc_pkt, r.pkt);
            b.outs     = r.mask;
            b.pkt      = r.pkt;
            b.pkt.data = '0;                     // Combined answer has no data
            exp_bc.push_back(b);
            void'(sent_q.pop_front());
          end else begin
            ch = r.mask[ch_addr_w-1:0];
            check_mask("icnt_aimc_pkt_valid", icnt_aimc_pkt_valid, ch_mask_t'(1) << ch);
            check_pkt("icnt_aimc_pkt", icnt_aimc_pkt, r.pkt);
            if (aimc_rdy[ch]) begin
              r.pkt.data = resp_data(r.pkt, ch);
              exp_uc[ch].push_back(r.pkt);
              void'(sent_q.pop_front());
            end
          end
        end
      end
      for (int i = 0; i < ch_num; i++) begin
        placed = 1'b0;
        if (aimc_pkt_valid[i] && aimc_pkt[i].bcast) begin
          for (int k = 0; k < exp_bc.size(); k++) begin
            if (!placed && exp_bc[k].outs[i]) begin  // Oldest broadcast waiting on i
              b         = exp_bc[k];
              b.outs[i] = 1'b0;
              exp_bc[k] = b;
              placed    = 1'b1;
            end
          end
        end
      end
      if (stalled) begin
        if (!icnt_dma_pkt_valid) begin
          report_failure("icnt_dma_pkt_valid dropped while dma_rdy was low");
        end else begin
          check_pkt("icnt_dma_pkt", icnt_dma_pkt, held_pkt);
          check_ch("icnt_dma_pkt_ch_addr", icnt_dma_pkt_ch_addr, held_ch);
        end
      end
      stalled  = icnt_dma_pkt_valid && !dma_rdy;
      held_pkt = icnt_dma_pkt;
      held_ch  = icnt_dma_pkt_ch_addr;
      if (icnt_dma_pkt_valid && dma_rdy) begin
        if (icnt_dma_pkt.bcast) begin
          if (exp_bc.size() == 0) begin
            report_failure("Broadcast response with no broadcast outstanding");
          end else begin
            b = exp_bc.pop_front();
            if (b.outs != '0) report_failure("Broadcast response before all channels answered");
            check_pkt("icnt_dma_pkt", icnt_dma_pkt, b.pkt);
            check_ch("icnt_dma_pkt_ch_addr", icnt_dma_pkt_ch_addr, '0);
            n_bc++;
          end
        end else begin
          ch = icnt_dma_pkt_ch_addr;
          if (exp_uc[ch].size() == 0) begin
            report_failure($sformatf("Unicast response on channel %0d not expected", ch));
          end else begin
            check_pkt("icnt_dma_pkt", icnt_dma_pkt, exp_uc[ch].pop_front());
            n_uc++;
          end
        end
      end
    end
  end

  initial begin
    pkt_t     p;
    ch_mask_t m;
    rst             = 1'b1;
    dma_pkt_valid   = 1'b0;
    dma_pkt         = '0;
    dma_pkt_ch_mask = '0;
    aimc_rdy        = '0;
    aimc_pkt_valid  = '0;
    aimc_pkt        = '{default: '0};
    dma_rdy         = 1'b0;
    repeat (4) begin
      @(posedge clk);
      check_reset();
    end
    #2 rst = 1'b0;
    @(posedge clk);
    check_reset();                               // First edge out of reset
    if (icnt_rdy !== 1'b1) report_failure("icnt_rdy did not rise after reset release");
    #2;
    for (int n = 0; n < n_req; n++) begin
      if (rand_bits(2) == 0) begin               // Idle gap now and then
        dma_pkt_valid = 1'b0;
        @(posedge clk);
        #2;
      end
      p.marker   = 1'(rand_bits(1));
      p.bcast    = (rand_bits(2) == 0);          // About one in four broadcasts
      p.prio     = prio_t'(rand_bits(2));
      p.req_type = req_type_t'(rand_bits(4));
      p.bk_addr  = bk_addr_t'(rand_bits(4));
      p.row_addr = row_addr_t'(rand_bits(14));
      p.col_addr = col_addr_t'(rand_bits(6));
      p.data     = data_t'(rand_bits(32));
      if (p.bcast) begin
        m = ch_mask_t'(rand_bits(ch_num));
        if (m == '0) m[0] = 1'b1;
      end else begin
        m = ch_mask_t'(rand_bits(ch_addr_w));    // Target in the low bits
      end
      dma_pkt         = p;
      dma_pkt_ch_mask = m;
      dma_pkt_valid   = 1'b1;
      @(posedge clk);
      while (!icnt_rdy) @(posedge clk);
      #2;
    end
    dma_pkt_valid = 1'b0;
    while (!drained()) @(posedge clk);
    repeat (20) @(posedge clk);                  // Catch late duplicates
    finish_run();
  end

endmodule

`default_nettype wire

//--- files.f
bcast_icnt_pkg.sv
sync_fifo.sv
req_dispatch.sv
bcast_resp_collector.sv
resp_arbiter.sv
bcast_icnt.sv
tb_bcast_icnt.sv

//--- Bender.yml
package:
  name: bcast_icnt

sources:
  - bcast_icnt_pkg.sv
  - sync_fifo.sv
  - req_dispatch.sv
  - bcast_resp_collector.sv
  - resp_arbiter.sv
  - bcast_icnt.sv
  - target: test
    files:
      - tb_bcast_icnt.sv
